//--- dnc_read_interface.f
hw/dnc_read_pkg.sv
hw/dnc_wb_regs.sv
hw/dnc_interface_split.sv
hw/dnc_read_keys.sv
hw/dnc_read_strengths.sv
hw/dnc_read_interface.sv
tests/dnc_read_tb_checks.sv
tests/dnc_read_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the read-interface testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module dnc_read_tb \
  -f dnc_read_interface.f \
  -o dnc_read_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/dnc_read_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "SIMULATION PASSED"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1

//--- tests/dnc_read_tb.sv
// Testbench top with clock, reset, Wishbone host tasks, LFSR data and final verdict
module dnc_read_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import dnc_read_pkg::*;

  logic     CLK = 1'b0;
  logic     RST;
  wb_m2s_t  wb_in;
  wb_s2m_t  wb_out;
  key_out_t key_out;
  str_out_t str_out;
  logic     done;

  // Error counts
  int mismatch_count;
  int failure_count;
  int timeouts = 0;

  logic [31:0] lfsr = 32'he25a_f0b7;

  // 100 ns period
  always #50 CLK = ~CLK;

  dnc_read_interface DUT (
    .CLK     (CLK),
    .RST     (RST),
    .wb_in   (wb_in),
    .wb_out  (wb_out),
    .key_out (key_out),
    .str_out (str_out),
    .done    (done)
  );

  dnc_read_tb_checks u_checks (
    .CLK            (CLK),
    .RST            (RST),
    .wb_in          (wb_in),
    .wb_out         (wb_out),
    .key_out        (key_out),
    .str_out        (str_out),
    .done           (done),
    .mismatch_count (mismatch_count),
    .failure_count  (failure_count)
  );

  ////////////////////
  // Host tasks
  ////////////////////

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int b = 0; b < n; b++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return v;
  endfunction

  task automatic set_test(input string name);
    u_checks.test_name = name;
    $display("Test %s", name);
  endtask

  // One classic cycle held until ack and followed by an idle clock
  task automatic bus_access(input logic we, input logic [ADR_W-1:0] adr,
                            input logic [DATA_W-1:0] dat);
    bit acked;
    acked = 1'b0;
    wb_in = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
    for (int n = 0; n < 16 && !acked; n++) begin
      @(posedge CLK);
      #1;
      acked = wb_out.ack;
    end
    if (!acked) begin
      timeouts++;
      $display("ERROR: no Wishbone ack within 16 clocks at address %0d", adr);
    end
    wb_in = '0;
    @(posedge CLK);
    #1;
  endtask

  task automatic wait_done(input int limit);
    bit seen;
    seen = 1'b0;
    for (int n = 0; n < limit && !seen; n++) begin
      @(posedge CLK);
      #1;
      seen = done;
    end
    if (!seen) begin
      timeouts++;
      $display("ERROR: done did not rise within %0d clocks", limit);
    end
  endtask

  // Whole frame of sizes, start, keys, strengths and status reads
  task automatic run_frame(input string name, input int r, input int w, input bit poke);
    logic [DATA_W-1:0] v;
    set_test(name);
    bus_access(1'b1, REG_SIZE_R, DATA_W'(r));
    bus_access(1'b1, REG_SIZE_W, DATA_W'(w));
    bus_access(1'b1, REG_CTRL, 32'd1);
    // Busy with done cleared by the start
    bus_access(1'b0, REG_CTRL, '0);
    for (int j = 0; j < r * w; j++) begin
      v = take_bits(32);
      // Every fourth key and the last key negative
      if (j % 4 == 3 || j == r * w - 1) v[31] = 1'b1;
      bus_access(1'b1, REG_ELEM, v);
      if (poke && j == 0) begin
        // Sizes locked mid-frame
        bus_access(1'b1, REG_SIZE_R, 32'd3);
        bus_access(1'b1, REG_SIZE_W, 32'd7);
        bus_access(1'b0, REG_SIZE_R, '0);
        bus_access(1'b0, REG_SIZE_W, '0);
      end
    end
    // Positive, zero, negative and near-maximum strengths
    for (int h = 0; h < r; h++) begin
      case (h % 4)
        0:       v = take_bits(20);
        1:       v = '0;
        2:       v = 32'h8000_0000 | take_bits(31);
        default: v = 32'h7fff_0000 | take_bits(16);
      endcase
      bus_access(1'b1, REG_ELEM, v);
    end
    wait_done(64);
    bus_access(1'b0, REG_CTRL, '0);
    bus_access(1'b0, REG_ELEM, '0);
  endtask

  ////////////////////
  // Sequence
  ////////////////////

  initial begin
    RST = 1'b1;
    wb_in = '0;
    repeat (8) @(posedge CLK);
    #1;
    RST = 1'b0;

    set_test("reset_defaults");
    bus_access(1'b0, REG_SIZE_R, '0);
    bus_access(1'b0, REG_SIZE_W, '0);
    bus_access(1'b0, REG_CTRL, '0);
    bus_access(1'b0, REG_ELEM, '0);

    // Nothing started so nothing may come out
    set_test("idle_elements");
    repeat (3) bus_access(1'b1, REG_ELEM, take_bits(32));
    bus_access(1'b0, REG_ELEM, '0);

    run_frame("frame_1x1", 1, 1, 1'b0);
    run_frame("frame_2x3", 2, 3, 1'b1);
    run_frame("frame_4x16", 4, 16, 1'b0);

    set_test("size_clamp");
    bus_access(1'b1, REG_SIZE_R, 32'd0);
    bus_access(1'b0, REG_SIZE_R, '0);
    bus_access(1'b1, REG_SIZE_R, 32'd9);
    bus_access(1'b0, REG_SIZE_R, '0);
    bus_access(1'b1, REG_SIZE_W, 32'd0);
    bus_access(1'b0, REG_SIZE_W, '0);
    bus_access(1'b1, REG_SIZE_W, 32'd100);
    bus_access(1'b0, REG_SIZE_W, '0);

    // Drain the pipeline
    repeat (4) @(posedge CLK);
    #1;
    $display("Errors: %0d mismatches, %0d failed checks, %0d timeouts",
             mismatch_count, failure_count, timeouts);
    if (mismatch_count == 0 && failure_count == 0 && timeouts == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- tests/dnc_read_tb_checks.sv
// Testbench checker with bus and done assertions and reference models of both streams
module dnc_read_tb_checks (
  input  logic                   CLK,
  input  logic                   RST,
  input  dnc_read_pkg::wb_m2s_t  wb_in,
  input  dnc_read_pkg::wb_s2m_t  wb_out,
  input  dnc_read_pkg::key_out_t key_out,
  input  dnc_read_pkg::str_out_t str_out,
  input  logic                   done,
  output int                     mismatch_count,
  output int                     failure_count
);
  timeunit 1ns;
  timeprecision 1ps;
  import dnc_read_pkg::*;

  // Current test, set by the testbench top
  string test_name = "reset";
  int    mismatches = 0;
  int    failures = 0;
  int    cycle = 0;

  // Host view of the register block
  bit                m_busy;
  bit                m_done;
  int                m_size_r;
  int                m_size_w;
  int                m_count;
  bit                read_pending;
  logic [DATA_W-1:0] read_exp;

  // Expected outputs and the sample cycle each is due
  key_out_t key_q[$];
  int       key_due[$];
  str_out_t str_q[$];
  int       str_due[$];

  assign mismatch_count = mismatches;
  assign failure_count = failures;

  ////////////////////
  // Reference rules
  ////////////////////

  // 1.0 + max(x,0), held at the largest positive Q16.16
  function automatic logic [DATA_W-1:0] oneplus_ref(input logic [DATA_W-1:0] x);
    longint v;
    v = longint'($signed(x));
    if (v < 0) v = 0;
    v = v + longint'(ONE_Q);
    if (v > 64'sh7fff_ffff) v = 64'sh7fff_ffff;
    return DATA_W'(v);
  endfunction

  // 0 reads back as 1, too large as the maximum
  function automatic int clamp_size(input logic [DATA_W-1:0] d, input int top);
    if (d == '0) return 1;
    if (d > DATA_W'(top)) return top;
    return int'(d);
  endfunction

  function automatic logic [DATA_W-1:0] read_value(input logic [ADR_W-1:0] adr);
    case (adr)
      REG_CTRL:   return {30'd0, m_done, m_busy};
      REG_SIZE_R: return DATA_W'(m_size_r);
      REG_SIZE_W: return DATA_W'(m_size_w);
      default:    return DATA_W'(m_count);
    endcase
  endfunction

  task automatic check_value(input string what, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (exp == act)
      else begin
        mismatches++;
        $display("MISMATCH %s %s: expected %h, actual %h", test_name, what, exp, act);
      end
  endtask

  // Keys in i-outer k-inner order, then one strength per head
  task automatic expect_element(input logic [DATA_W-1:0] dat);
    key_out_t ek;
    str_out_t es;
    int       h;
    if (m_count < m_size_r * m_size_w) begin
      ek.valid = 1'b1;
      ek.i = IDX_R_W'(m_count / m_size_w);
      ek.k = IDX_W_W'(m_count % m_size_w);
      ek.row_last = (m_count % m_size_w == m_size_w - 1);
      ek.frame_last = (m_count == m_size_r * m_size_w - 1);
      ek.data = dat;
      key_q.push_back(ek);
      key_due.push_back(cycle + 3);
    end else begin
      h = m_count - m_size_r * m_size_w;
      es.valid = 1'b1;
      es.i = IDX_R_W'(h);
      es.frame_last = (h == m_size_r - 1);
      es.data = oneplus_ref(dat);
      str_q.push_back(es);
      str_due.push_back(cycle + 3);
    end
    m_count++;
  endtask

  ////////////////////
  // Model, stepped on each edge
  ////////////////////

  always @(posedge CLK) begin : model
    key_out_t ek;
    str_out_t es;
    bit       busy_pre;
    if (RST) begin
      m_busy = 1'b0;
      m_done = 1'b0;
      m_size_r = 1;
      m_size_w = 1;
      m_count = 0;
      read_pending = 1'b0;
      cycle = 0;
      key_q.delete();
      key_due.delete();
      str_q.delete();
      str_due.delete();
    end else begin
      cycle++;
      if (key_out.valid) begin
        if (key_q.size() == 0) begin
          failures++;
          $display("ERROR: %s: key came out with no key pending", test_name);
        end else begin
          ek = key_q.pop_front();
          check_value("key cycle", 32'(key_due.pop_front()), 32'(cycle));
          check_value("key data", ek.data, key_out.data);
          check_value("key i", 32'(ek.i), 32'(key_out.i));
          check_value("key k", 32'(ek.k), 32'(key_out.k));
          check_value("key row_last", 32'(ek.row_last), 32'(key_out.row_last));
          check_value("key frame_last", 32'(ek.frame_last), 32'(key_out.frame_last));
        end
      end
      if (str_out.valid) begin
        if (str_q.size() == 0) begin
          failures++;
          $display("ERROR: %s: strength came out with no strength pending", test_name);
        end else begin
          es = str_q.pop_front();
          check_value("strength cycle", 32'(str_due.pop_front()), 32'(cycle));
          check_value("strength data", es.data, str_out.data);
          check_value("strength i", 32'(es.i), 32'(str_out.i));
          check_value("strength frame_last", 32'(es.frame_last), 32'(str_out.frame_last));
        end
      end
      // Overdue entries never came out
      while (key_due.size() != 0 && key_due[0] < cycle) begin
        failures++;
        $display("ERROR: %s: an expected key never came out", test_name);
        key_q.delete(0);
        key_due.delete(0);
      end
      while (str_due.size() != 0 && str_due[0] < cycle) begin
        failures++;
        $display("ERROR: %s: an expected strength never came out", test_name);
        str_q.delete(0);
        str_due.delete(0);
      end
      if (wb_out.ack && read_pending) begin
        check_value("register read", read_exp, wb_out.dat);
        read_pending = 1'b0;
      end
      busy_pre = m_busy;
      // Read captures the state before this edge
      if (wb_in.cyc && wb_in.stb && !wb_out.ack && !wb_in.we) begin
        read_exp = read_value(wb_in.adr);
        read_pending = 1'b1;
      end
      if (str_out.valid && str_out.frame_last) begin
        m_busy = 1'b0;
        m_done = 1'b1;
      end
      // Start wins over a frame end on the same edge
      if (wb_in.cyc && wb_in.stb && !wb_out.ack && wb_in.we) begin
        case (wb_in.adr)
          REG_CTRL: begin
            if (wb_in.dat[0]) begin
              m_busy = 1'b1;
              m_done = 1'b0;
              m_count = 0;
            end
          end
          REG_SIZE_R: if (!busy_pre) m_size_r = clamp_size(wb_in.dat, MAX_R);
          REG_SIZE_W: if (!busy_pre) m_size_w = clamp_size(wb_in.dat, MAX_W);
          default: begin
            if (busy_pre && m_count < m_size_r * (m_size_w + 1)) expect_element(wb_in.dat);
          end
        endcase
      end
    end
  end

  ////////////////////
  // Bus and done timing
  ////////////////////

  // Ack on the clock after a fresh strobe
  a_ack_next: assert property (@(posedge CLK) disable iff (RST)
    (wb_in.cyc && wb_in.stb && !wb_out.ack) |=> wb_out.ack)
    else begin
      failures++;
      $display("ERROR: %s: no Wishbone ack one clock after the strobe", test_name);
    end

  a_ack_single: assert property (@(posedge CLK) disable iff (RST)
    wb_out.ack |=> !wb_out.ack)
    else begin
      failures++;
      $display("ERROR: %s: Wishbone ack held longer than one clock", test_name);
    end

  // No ack without a live access
  a_ack_live: assert property (@(posedge CLK) disable iff (RST)
    wb_out.ack |-> $past(wb_in.cyc && wb_in.stb))
    else begin
      failures++;
      $display("ERROR: %s: Wishbone ack without an access", test_name);
    end

  a_done_rise: assert property (@(posedge CLK) disable iff (RST)
    (str_out.valid && str_out.frame_last) |=> done)
    else begin
      failures++;
      $display("ERROR: %s: done did not follow the last strength", test_name);
    end

endmodule

//--- hw/dnc_read_interface.sv
// Read-interface top level chaining register front end, splitter and read stages
module dnc_read_interface (
  input  logic                   CLK,
  input  logic                   RST,
  input  dnc_read_pkg::wb_m2s_t  wb_in,
  output dnc_read_pkg::wb_s2m_t  wb_out,
  output dnc_read_pkg::key_out_t key_out,
  output dnc_read_pkg::str_out_t str_out,
  output logic                   done
);
  import dnc_read_pkg::*;

  ////////////////////
  // Stage links
  ////////////////////

  elem_t   elem;
  tagged_t tagged_elem;
  logic    frame_done;

  // Last strength out ends the frame
  assign frame_done = str_out.valid & str_out.frame_last;

  // Host registers and element push
  dnc_wb_regs u_regs (
    .CLK        (CLK),
    .RST        (RST),
    .wb_in      (wb_in),
    .wb_out     (wb_out),
    .frame_done (frame_done),
    .elem       (elem),
    .done       (done)
  );

  // Field and index tagging
  dnc_interface_split u_split (
    .CLK         (CLK),
    .RST         (RST),
    .elem        (elem),
    .tagged_elem (tagged_elem)
  );

  // Both read stages see the same tagged stream
  dnc_read_keys u_keys (
    .CLK         (CLK),
    .RST         (RST),
    .tagged_elem (tagged_elem),
    .key_out     (key_out)
  );

  dnc_read_strengths u_strengths (
    .CLK         (CLK),
    .RST         (RST),
    .tagged_elem (tagged_elem),
    .str_out     (str_out)
  );

endmodule

//--- hw/dnc_read_strengths.sv
// Read-strength stage with saturating rectified oneplus and frame-end mark
module dnc_read_strengths (
  input  logic                   CLK,
  input  logic                   RST,
  input  dnc_read_pkg::tagged_t  tagged_elem,
  output dnc_read_pkg::str_out_t str_out
);
  import dnc_read_pkg::*;

  // Strength select
  logic               is_str;

  // Oneplus datapath
  logic [DATA_W-1:0]  rect;
  logic [DATA_W-1:0]  sum;
  logic [DATA_W-1:0]  result;

  // Output registers
  logic               valid_q;
  logic [IDX_R_W-1:0] i_q;
  logic               frame_last_q;
  logic [DATA_W-1:0]  data_q;

  assign is_str = tagged_elem.valid && (tagged_elem.field == FIELD_STRENGTH);

  ////////////////////
  // Rectified oneplus
  ////////////////////

  // max(x,0) decided by the sign bit
  assign rect = tagged_elem.data[DATA_W-1] ? '0 : tagged_elem.data;
  // Non-negative plus 1.0 stays below 2^32 so overflow only reaches bit 31
  assign sum = rect + ONE_Q;
  assign result = sum[DATA_W-1] ? MAX_Q : sum;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= is_str;
    end
  end

  always_ff @(posedge CLK) begin
    if (is_str) begin
      data_q <= result;
      i_q <= tagged_elem.i;
      // Last head closes the frame
      frame_last_q <= tagged_elem.frame_last;
    end
  end

  assign str_out = '{
    valid:      valid_q,
    i:          i_q,
    frame_last: frame_last_q,
    data:       data_q
  };

  // Strengths are at least 1.0 after the stage
  a_min_one: assert property (@(posedge CLK) disable iff (RST)
    valid_q |-> ($signed(data_q) >= $signed(ONE_Q)));

endmodule

//--- hw/dnc_read_keys.sv
// Read-key stage forwarding keys with position, row-end and frame-end marks
module dnc_read_keys (
  input  logic                   CLK,
  input  logic                   RST,
  input  dnc_read_pkg::tagged_t  tagged_elem,
  output dnc_read_pkg::key_out_t key_out
);
  import dnc_read_pkg::*;

  // Key select
  logic               is_key;

  // Output registers
  logic               valid_q;
  logic [IDX_R_W-1:0] i_q;
  logic [IDX_W_W-1:0] k_q;
  logic               row_last_q;
  logic               frame_last_q;
  logic [DATA_W-1:0]  data_q;

  // Only key elements pass here
  assign is_key = tagged_elem.valid && (tagged_elem.field == FIELD_KEY);

  ////////////////////
  // Valid
  ////////////////////

  // k(t;i;k) = k^(t;i;k) with one clock per key
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      valid_q <= 1'b0;
    end else begin
      // Low in every cycle without a key
      valid_q <= is_key;
    end
  end

  ////////////////////
  // Key and position
  ////////////////////

  always_ff @(posedge CLK) begin
    if (is_key) begin
      data_q <= tagged_elem.data;
      i_q <= tagged_elem.i;
      k_q <= tagged_elem.k;
      // Per-head enable closing one i row
      row_last_q <= tagged_elem.row_last;
      // Last key of the frame only
      frame_last_q <= tagged_elem.frame_last;
    end
  end

  assign key_out = '{
    valid:      valid_q,
    i:          i_q,
    k:          k_q,
    row_last:   row_last_q,
    frame_last: frame_last_q,
    data:       data_q
  };

  // Frame end only where a row also ends
  a_frame_row: assert property (@(posedge CLK) disable iff (RST)
    (valid_q && frame_last_q) |-> row_last_q);

endmodule

//--- hw/dnc_interface_split.sv
// Element splitter tagging each element as read key (i,k) or read strength (i)
module dnc_interface_split (
  input  logic                  CLK,
  input  logic                  RST,
  input  dnc_read_pkg::elem_t   elem,
  output dnc_read_pkg::tagged_t tagged_elem
);
  import dnc_read_pkg::*;

  // Position in the frame
  logic [IDX_R_W-1:0] i_q;
  logic [IDX_W_W-1:0] k_q;
  field_t             phase_q;

  // Position decode against the carried geometry
  logic               k_last;
  logic               i_last;

  // Registered output
  logic               valid_q;
  field_t             field_q;
  logic [IDX_R_W-1:0] i_out_q;
  logic [IDX_W_W-1:0] k_out_q;
  logic               row_last_q;
  logic               frame_last_q;
  logic [DATA_W-1:0]  data_q;

  assign k_last = (SZ_W_W'(k_q) == elem.size_w - SZ_W_W'(1));
  assign i_last = (SZ_R_W'(i_q) == elem.size_r - SZ_R_W'(1));

  ////////////////////
  // Frame counters
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      i_q <= '0;
      k_q <= '0;
      phase_q <= FIELD_KEY;
      valid_q <= 1'b0;
    end else begin
      valid_q <= elem.valid;
      if (elem.valid) begin
        if (phase_q == FIELD_KEY) begin
          // Inner k loop inside the outer i loop
          if (k_last) begin
            k_q <= '0;
            if (i_last) begin
              i_q <= '0;
              phase_q <= FIELD_STRENGTH;
            end else begin
              i_q <= i_q + 1'b1;
            end
          end else begin
            k_q <= k_q + 1'b1;
          end
        end else begin
          // One strength per head before the keys return
          if (i_last) begin
            i_q <= '0;
            phase_q <= FIELD_KEY;
          end else begin
            i_q <= i_q + 1'b1;
          end
        end
      end
    end
  end

  ////////////////////
  // Tag payload
  ////////////////////

  always_ff @(posedge CLK) begin
    if (elem.valid) begin
      field_q <= phase_q;
      i_out_q <= i_q;
      data_q <= elem.data;
      if (phase_q == FIELD_KEY) begin
        k_out_q <= k_q;
        row_last_q <= k_last;
        frame_last_q <= k_last && i_last;
      end else begin
        // Strength is a row of its own
        k_out_q <= '0;
        row_last_q <= 1'b1;
        frame_last_q <= i_last;
      end
    end
  end

  assign tagged_elem = '{valid: valid_q, field: field_q, i: i_out_q, k: k_out_q,
                         row_last: row_last_q, frame_last: frame_last_q, data: data_q};

  // Word index stays inside the geometry the register block latched
  a_k_range: assert property (@(posedge CLK) disable iff (RST)
    elem.valid |-> (SZ_W_W'(k_q) < elem.size_w));

endmodule

//--- hw/dnc_wb_regs.sv
// Wishbone classic slave with control, size and status registers and element push
module dnc_wb_regs (
  input  logic                  CLK,
  input  logic                  RST,
  input  dnc_read_pkg::wb_m2s_t wb_in,
  output dnc_read_pkg::wb_s2m_t wb_out,
  input  logic                  frame_done,
  output dnc_read_pkg::elem_t   elem,
  output logic                  done
);
  import dnc_read_pkg::*;

  // Bus handshake
  logic              ack_q;
  logic              access;
  logic              wr;
  logic [DATA_W-1:0] rd_dat_q;

  // Frame state
  logic              busy_q;
  logic              done_q;
  logic [SZ_R_W-1:0] size_r_q;
  logic [SZ_W_W-1:0] size_w_q;
  logic [CNT_W-1:0]  count_q;
  logic [CNT_W-1:0]  frame_len;
  logic              push;
  logic              elem_valid_q;
  logic [DATA_W-1:0] elem_data_q;

  // Size 0 becomes 1, anything above the maximum is held at the maximum
  function automatic logic [SZ_R_W-1:0] clamp_r(input logic [DATA_W-1:0] v);
    if (v == '0) return SZ_R_W'(1);
    if (v > MAX_R) return SZ_R_W'(MAX_R);
    return v[SZ_R_W-1:0];
  endfunction

  function automatic logic [SZ_W_W-1:0] clamp_w(input logic [DATA_W-1:0] v);
    if (v == '0) return SZ_W_W'(1);
    if (v > MAX_W) return SZ_W_W'(MAX_W);
    return v[SZ_W_W-1:0];
  endfunction

  // New access seen, ack goes out on the next edge
  assign access = wb_in.cyc & wb_in.stb & ~ack_q;
  assign wr = access & wb_in.we;

  // Keys plus one strength per head
  assign frame_len = size_r_q * (size_w_q + 1'b1);

  // Elements only inside a started frame, surplus ones dropped
  assign push = wr && (wb_in.adr == REG_ELEM) && busy_q && (count_q != frame_len);

  ////////////////////
  // Control state
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      ack_q <= 1'b0;
      busy_q <= 1'b0;
      done_q <= 1'b0;
      size_r_q <= SZ_R_W'(1);
      size_w_q <= SZ_W_W'(1);
      count_q <= '0;
      elem_valid_q <= 1'b0;
    end else begin
      ack_q <= access;
      elem_valid_q <= push;
      if (push) count_q <= count_q + 1'b1;
      // Last strength left the pipeline
      if (frame_done) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end
      if (wr) begin
        case (wb_in.adr)
          REG_CTRL: begin
            // Start wins over a frame_done on the same edge
            if (wb_in.dat[0]) begin
              busy_q <= 1'b1;
              done_q <= 1'b0;
              count_q <= '0;
            end
          end
          REG_SIZE_R: if (!busy_q) size_r_q <= clamp_r(wb_in.dat);
          REG_SIZE_W: if (!busy_q) size_w_q <= clamp_w(wb_in.dat);
          default: ;
        endcase
      end
    end
  end

  ////////////////////
  // Read data and element payload
  ////////////////////

  always_ff @(posedge CLK) begin
    if (access && !wb_in.we) begin
      case (wb_in.adr)
        REG_CTRL:   rd_dat_q <= {{(DATA_W-2){1'b0}}, done_q, busy_q};
        REG_SIZE_R: rd_dat_q <= DATA_W'(size_r_q);
        REG_SIZE_W: rd_dat_q <= DATA_W'(size_w_q);
        default:    rd_dat_q <= DATA_W'(count_q);
      endcase
    end
    if (push) elem_data_q <= wb_in.dat;
  end

  // Sizes cannot change while busy, so they travel as latched
  assign elem = '{valid: elem_valid_q, data: elem_data_q, size_r: size_r_q, size_w: size_w_q};
  assign wb_out = '{ack: ack_q, dat: rd_dat_q};
  assign done = done_q;

  // One ack per access
  a_ack_single: assert property (@(posedge CLK) disable iff (RST) ack_q |=> !ack_q);
  // Nothing leaves outside a frame
  a_elem_busy: assert property (@(posedge CLK) disable iff (RST) elem_valid_q |-> busy_q);

endmodule

//--- hw/dnc_read_pkg.sv
// Read-interface localparams, Wishbone and pipeline structs, register map
package dnc_read_pkg;

  ////////////////////
  // Sizes
  ////////////////////

  // Q16.16 signed element
  localparam int DATA_W = 32;
  localparam int MAX_R = 4;
  localparam int MAX_W = 16;
  localparam int IDX_R_W = 2;
  localparam int IDX_W_W = 4;
  // Size registers hold 1..MAX, one bit wider than the index
  localparam int SZ_R_W = $clog2(MAX_R + 1);
  localparam int SZ_W_W = $clog2(MAX_W + 1);
  // Keys plus strengths of the largest frame
  localparam int CNT_W = $clog2(MAX_R * (MAX_W + 1) + 1);
  localparam int ADR_W = 2;

  // Fixed-point constants
  localparam logic [DATA_W-1:0] ONE_Q = 32'h0001_0000;
  localparam logic [DATA_W-1:0] MAX_Q = 32'h7fff_ffff;

  ////////////////////
  // Register map
  ////////////////////

  localparam logic [ADR_W-1:0] REG_CTRL = 2'd0;
  localparam logic [ADR_W-1:0] REG_SIZE_R = 2'd1;
  localparam logic [ADR_W-1:0] REG_SIZE_W = 2'd2;
  localparam logic [ADR_W-1:0] REG_ELEM = 2'd3;

  ////////////////////
  // Bus and stream types
  ////////////////////

  typedef struct packed {
    logic              cyc;
    logic              stb;
    logic              we;
    logic [ADR_W-1:0]  adr;
    logic [DATA_W-1:0] dat;
  } wb_m2s_t;

  typedef struct packed {
    logic              ack;
    logic [DATA_W-1:0] dat;
  } wb_s2m_t;

  // Element plus the frame geometry latched at start
  typedef struct packed {
    logic              valid;
    logic [DATA_W-1:0] data;
    logic [SZ_R_W-1:0] size_r;
    logic [SZ_W_W-1:0] size_w;
  } elem_t;

  typedef enum logic {
    FIELD_KEY,
    FIELD_STRENGTH
  } field_t;

  typedef struct packed {
    logic               valid;
    field_t             field;
    logic [IDX_R_W-1:0] i;
    logic [IDX_W_W-1:0] k;
    logic               row_last;
    logic               frame_last;
    logic [DATA_W-1:0]  data;
  } tagged_t;

  typedef struct packed {
    logic               valid;
    logic [IDX_R_W-1:0] i;
    logic [IDX_W_W-1:0] k;
    logic               row_last;
    logic               frame_last;
    logic [DATA_W-1:0]  data;
  } key_out_t;

  typedef struct packed {
    logic               valid;
    logic [IDX_R_W-1:0] i;
    logic               frame_last;
    logic [DATA_W-1:0]  data;
  } str_out_t;

endpackage
